/* source/exu_params.svh */
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

`define EXU_XLEN 64

// RV64 major opcodes
`define EXU_OP_R      7'b0110011
`define EXU_OP_R64    7'b0111011 // word register forms
`define EXU_OP_I      7'b0010011
`define EXU_OP_I64    7'b0011011 // word immediate forms
`define EXU_OP_LUI    7'b0110111
`define EXU_OP_AUIPC  7'b0010111
`define EXU_OP_LOAD   7'b0000011
`define EXU_OP_STORE  7'b0100011
`define EXU_OP_JAL    7'b1101111
`define EXU_OP_JALR   7'b1100111
`define EXU_OP_BRANCH 7'b1100011
`define EXU_OP_SYSTEM 7'b1110011

`endif

/* source/exu_pkg.sv */
`include "exu_params.svh"

package exu_pkg;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLL,
    SRL,
    SRA,
    SLT,
    SLTU,
    LI,
    BRANCH,
    NONE
  } alu_op_e;

  // request as the issuing stage presents it
  typedef struct packed {
    logic [`EXU_XLEN-1:0] src1;
    logic [`EXU_XLEN-1:0] src2;      // already immediate-selected
    logic [6:0]           opcode;
    logic [2:0]           func3;
    logic                 func7_alt; // func7 bit 5
    logic                 mul_en;
    logic                 div_en;
  } exu_req_t;

  typedef struct packed {
    logic word;
    logic a_signed;
    logic b_signed;
    logic take_high; // mul only
    logic take_rem;  // div only
  } md_cmd_t;

  typedef struct packed {
    alu_op_e op;
    logic    word;
    md_cmd_t md;
  } exu_dec_t;

endpackage

/* source/exu_op_decode.sv */
`include "exu_params.svh"

module exu_op_decode
  import exu_pkg::*;
(
  input  exu_req_t req_i,
  output exu_dec_t dec_o
);

  logic is_reg;

  always_comb begin
    // func7 alt only means sub on register forms, addi ignores it
    is_reg = (req_i.opcode == `EXU_OP_R) || (req_i.opcode == `EXU_OP_R64);
    dec_o.word = (req_i.opcode == `EXU_OP_R64) || (req_i.opcode == `EXU_OP_I64);

    case (req_i.opcode)
      `EXU_OP_R, `EXU_OP_R64, `EXU_OP_I, `EXU_OP_I64: begin
        case (req_i.func3)
          3'b000:  dec_o.op = (is_reg && req_i.func7_alt) ? SUB : ADD;
          3'b001:  dec_o.op = SLL;
          3'b010:  dec_o.op = SLT;
          3'b011:  dec_o.op = SLTU;
          3'b100:  dec_o.op = XOR;
          3'b101:  dec_o.op = req_i.func7_alt ? SRA : SRL;
          3'b110:  dec_o.op = OR;
          default: dec_o.op = AND;
        endcase
      end
      `EXU_OP_LUI:    dec_o.op = LI;
      `EXU_OP_AUIPC,
      `EXU_OP_LOAD,
      `EXU_OP_STORE,
      `EXU_OP_JAL,
      `EXU_OP_JALR:   dec_o.op = ADD; // address / target add
      `EXU_OP_BRANCH: dec_o.op = BRANCH;
      default:        dec_o.op = NONE; // system and unknown give zero
    endcase

    // M extension, func3 picks signedness and half
    dec_o.md.word      = req_i.opcode == `EXU_OP_R64;
    dec_o.md.a_signed  = (req_i.func3 == 3'b000) || (req_i.func3 == 3'b001) ||
                         (req_i.func3 == 3'b010) || (req_i.func3 == 3'b100) ||
                         (req_i.func3 == 3'b110);
    dec_o.md.b_signed  = (req_i.func3 == 3'b000) || (req_i.func3 == 3'b001) ||
                         (req_i.func3 == 3'b100) || (req_i.func3 == 3'b110);
    dec_o.md.take_high = req_i.func3 != 3'b000;
    dec_o.md.take_rem  = req_i.func3[1];
  end

endmodule

/* source/exu_alu.sv */
`include "exu_params.svh"

module exu_alu
  import exu_pkg::*;
(
  input  logic [`EXU_XLEN-1:0] src1_i,
  input  logic [`EXU_XLEN-1:0] src2_i,
  input  logic [2:0]           func3_i,
  input  logic [6:0]           opcode_i,
  input  exu_dec_t             dec_i,
  output logic [`EXU_XLEN-1:0] result_o
);

  logic [5:0]           shamt;
  logic [`EXU_XLEN-1:0] sh_src;
  logic [`EXU_XLEN-1:0] sum;
  logic [`EXU_XLEN-1:0] diff;
  logic [`EXU_XLEN-1:0] raw;
  logic                 eq;
  logic                 lt;
  logic                 ltu;
  logic                 br_take;

  assign sum  = src1_i + src2_i;
  assign diff = src1_i - src2_i;
  assign eq   = src1_i == src2_i;
  assign lt   = $signed(src1_i) < $signed(src2_i);
  assign ltu  = src1_i < src2_i;

  // word forms shift by five bits only
  assign shamt = dec_i.word ? {1'b0, src2_i[4:0]} : src2_i[5:0];

  always_comb begin
    if (dec_i.word) begin
      // right shifts on words must see only the low half
      sh_src = (dec_i.op == SRA) ? {{32{src1_i[31]}}, src1_i[31:0]}
                                 : {32'b0, src1_i[31:0]};
    end else begin
      sh_src = src1_i;
    end
  end

  always_comb begin
    case (func3_i)
      3'b000:  br_take = eq;   // beq
      3'b001:  br_take = !eq;  // bne
      3'b100:  br_take = lt;
      3'b101:  br_take = !lt;
      3'b110:  br_take = ltu;
      3'b111:  br_take = !ltu;
      default: br_take = 1'b0;
    endcase
  end

  always_comb begin
    case (dec_i.op)
      ADD:     raw = sum;
      SUB:     raw = diff;
      AND:     raw = src1_i & src2_i;
      OR:      raw = src1_i | src2_i;
      XOR:     raw = src1_i ^ src2_i;
      SLL:     raw = src1_i << shamt;
      SRL:     raw = sh_src >> shamt;
      SRA:     raw = $signed(sh_src) >>> shamt;
      SLT:     raw = {63'b0, lt};
      SLTU:    raw = {63'b0, ltu};
      LI:      raw = src2_i; // lui immediate
      BRANCH:  raw = {63'b0, br_take};
      default: raw = '0;
    endcase
  end

  always_comb begin
    if (opcode_i == `EXU_OP_JALR) begin
      result_o = {sum[63:1], 1'b0}; // target aligned
    end else if (dec_i.word) begin
      result_o = {{32{raw[31]}}, raw[31:0]};
    end else begin
      result_o = raw;
    end
  end

endmodule

/* source/exu_mul.sv */
`include "exu_params.svh"

module exu_mul
  import exu_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset_i,
  input  logic                 start_i,
  input  logic [`EXU_XLEN-1:0] a_i,
  input  logic [`EXU_XLEN-1:0] b_i,
  input  md_cmd_t              cmd_i,
  output logic                 done_o,
  output logic [`EXU_XLEN-1:0] result_o
);

  logic                   busy;
  logic [5:0]             cnt;
  logic                   load;
  logic                   a_neg;
  logic                   b_neg;
  logic                   neg;
  md_cmd_t                cmd_q;
  logic [2*`EXU_XLEN-1:0] mcand;
  logic [`EXU_XLEN-1:0]   mplier;
  logic [2*`EXU_XLEN-1:0] acc;
  logic [2*`EXU_XLEN-1:0] acc_sum;

  assign a_neg   = cmd_i.a_signed & a_i[63];
  assign b_neg   = cmd_i.b_signed & b_i[63];
  assign load    = start_i & ~busy & ~done_o; // no restart in the done cycle
  assign acc_sum = acc + (mplier[0] ? mcand : '0);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      busy   <= 1'b0;
      cnt    <= '0;
      done_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (load) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (busy) begin
        cnt <= cnt + 6'd1;
        if (cnt == 6'd63) begin
          busy   <= 1'b0;
          done_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      mcand  <= {64'b0, (a_neg ? -a_i : a_i)};
      mplier <= b_neg ? -b_i : b_i;
      neg    <= a_neg ^ b_neg;
      cmd_q  <= cmd_i;
      acc    <= '0;
    end else if (busy) begin
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
      // last step folds in the sign
      acc    <= (cnt == 6'd63 && neg) ? -acc_sum : acc_sum;
    end
  end

  always_comb begin
    if (cmd_q.take_high) begin
      result_o = acc[127:64];
    end else if (cmd_q.word) begin
      result_o = {{32{acc[31]}}, acc[31:0]}; // mulw
    end else begin
      result_o = acc[63:0];
    end
  end

endmodule

/* source/exu_div.sv */
`include "exu_params.svh"

module exu_div
  import exu_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset_i,
  input  logic                 start_i,
  input  logic [`EXU_XLEN-1:0] a_i,
  input  logic [`EXU_XLEN-1:0] b_i,
  input  md_cmd_t              cmd_i,
  output logic                 done_o,
  output logic [`EXU_XLEN-1:0] result_o
);

  logic                 busy;
  logic                 fix;
  logic [5:0]           cnt;
  logic                 load;
  logic [`EXU_XLEN-1:0] a_ext;
  logic [`EXU_XLEN-1:0] b_ext;
  logic                 a_neg;
  logic                 b_neg;
  logic                 q_neg;
  logic                 r_neg;
  logic                 by_zero;
  md_cmd_t              cmd_q;
  logic [`EXU_XLEN-1:0] quo;   // holds the dividend bits while shifting
  logic [`EXU_XLEN-1:0] rem;
  logic [`EXU_XLEN-1:0] dvs;
  logic [`EXU_XLEN-1:0] dvd;
  logic [`EXU_XLEN:0]   shifted;
  logic [`EXU_XLEN+1:0] trial;
  logic [`EXU_XLEN-1:0] pick;

  always_comb begin
    if (cmd_i.word) begin
      a_ext = cmd_i.a_signed ? {{32{a_i[31]}}, a_i[31:0]} : {32'b0, a_i[31:0]};
      b_ext = cmd_i.b_signed ? {{32{b_i[31]}}, b_i[31:0]} : {32'b0, b_i[31:0]};
    end else begin
      a_ext = a_i;
      b_ext = b_i;
    end
  end

  assign a_neg   = cmd_i.a_signed & a_ext[63];
  assign b_neg   = cmd_i.b_signed & b_ext[63];
  assign load    = start_i & ~busy & ~fix & ~done_o;
  assign shifted = {rem, quo[63]};
  assign trial   = {1'b0, shifted} - {2'b0, dvs}; // msb set means restore

  always_ff @(posedge clk) begin
    if (reset_i) begin
      busy   <= 1'b0;
      fix    <= 1'b0;
      cnt    <= '0;
      done_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (load) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (busy) begin
        cnt <= cnt + 6'd1;
        if (cnt == 6'd63) begin
          busy <= 1'b0;
          fix  <= 1'b1;
        end
      end else if (fix) begin
        fix    <= 1'b0;
        done_o <= 1'b1;
      end
    end
  end

  // most negative / -1 falls out of the magnitude path unchanged
  always_ff @(posedge clk) begin
    if (load) begin
      quo     <= a_neg ? -a_ext : a_ext;
      rem     <= '0;
      dvs     <= b_neg ? -b_ext : b_ext;
      dvd     <= a_ext;
      q_neg   <= a_neg ^ b_neg;
      r_neg   <= a_neg;
      by_zero <= b_ext == '0;
      cmd_q   <= cmd_i;
    end else if (busy) begin
      quo <= {quo[62:0], ~trial[65]};
      rem <= trial[65] ? shifted[63:0] : trial[63:0];
    end else if (fix) begin
      if (by_zero) begin
        quo <= '1;
        rem <= dvd;
      end else begin
        quo <= q_neg ? -quo : quo;
        rem <= r_neg ? -rem : rem; // remainder takes the dividend sign
      end
    end
  end

  assign pick     = cmd_q.take_rem ? rem : quo;
  assign result_o = cmd_q.word ? {{32{pick[31]}}, pick[31:0]} : pick;

endmodule

/* source/exu_top.sv */
`include "exu_params.svh"

module exu_top
  import exu_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset_i,
  input  exu_req_t             req_i,
  input  logic                 valid_i,
  output logic                 ready_o,
  output logic [`EXU_XLEN-1:0] result_o
);

  exu_dec_t             dec;
  logic                 mul_start;
  logic                 div_start;
  logic                 mul_done;
  logic                 div_done;
  logic [`EXU_XLEN-1:0] alu_result;
  logic [`EXU_XLEN-1:0] mul_result;
  logic [`EXU_XLEN-1:0] div_result;

  assign mul_start = valid_i & req_i.mul_en;
  assign div_start = valid_i & req_i.div_en;

  exu_op_decode exu_op_decode_inst (
    .req_i (req_i),
    .dec_o (dec)
  );

  exu_alu exu_alu_inst (
    .src1_i   (req_i.src1),
    .src2_i   (req_i.src2),
    .func3_i  (req_i.func3),
    .opcode_i (req_i.opcode),
    .dec_i    (dec),
    .result_o (alu_result)
  );

  exu_mul exu_mul_inst (
    .clk      (clk),
    .reset_i  (reset_i),
    .start_i  (mul_start),
    .a_i      (req_i.src1),
    .b_i      (req_i.src2),
    .cmd_i    (dec.md),
    .done_o   (mul_done),
    .result_o (mul_result)
  );

  exu_div exu_div_inst (
    .clk      (clk),
    .reset_i  (reset_i),
    .start_i  (div_start),
    .a_i      (req_i.src1),
    .b_i      (req_i.src2),
    .cmd_i    (dec.md),
    .done_o   (div_done),
    .result_o (div_result)
  );

  // plain alu requests complete in the same cycle
  assign ready_o  = req_i.mul_en ? mul_done :
                    req_i.div_en ? div_done : valid_i;
  assign result_o = req_i.mul_en ? mul_result :
                    req_i.div_en ? div_result : alu_result;

endmodule

/* verif/exu_checker.sv */
`include "exu_params.svh"

module exu_checker
  import exu_pkg::*;
(
  input logic                 clk,
  input logic                 reset_i,
  input exu_req_t             req_i,
  input logic                 valid_i,
  input logic                 ready_i,
  input logic [`EXU_XLEN-1:0] result_i,
  input logic                 mul_load_i,
  input logic                 div_load_i,
  input logic                 mul_done_i,
  input logic                 div_done_i
);

  int fail_cnt = 0;

  function automatic logic [63:0] alu_ref(input exu_req_t r);
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] res;
    logic        word;
    a = r.src1;
    b = r.src2;
    word = (r.opcode == `EXU_OP_R64) || (r.opcode == `EXU_OP_I64);
    case (r.opcode)
      `EXU_OP_R, `EXU_OP_R64, `EXU_OP_I, `EXU_OP_I64: begin
        case (r.func3)
          3'b000: begin
            // only register forms have sub
            if (r.func7_alt && (r.opcode == `EXU_OP_R || r.opcode == `EXU_OP_R64))
              res = a - b;
            else
              res = a + b;
          end
          3'b001:  res = word ? a << b[4:0] : a << b[5:0];
          3'b010:  res = {63'b0, $signed(a) < $signed(b)};
          3'b011:  res = {63'b0, a < b};
          3'b100:  res = a ^ b;
          3'b101: begin
            if (word)
              res = r.func7_alt ? {32'b0, 32'($signed(a[31:0]) >>> b[4:0])}
                                : {32'b0, a[31:0] >> b[4:0]};
            else if (r.func7_alt)
              res = $signed(a) >>> b[5:0];
            else
              res = a >> b[5:0];
          end
          3'b110:  res = a | b;
          default: res = a & b;
        endcase
      end
      `EXU_OP_LUI: res = b;
      `EXU_OP_AUIPC, `EXU_OP_LOAD, `EXU_OP_STORE, `EXU_OP_JAL: res = a + b;
      `EXU_OP_JALR: res = (a + b) & ~64'd1;
      `EXU_OP_BRANCH: begin
        case (r.func3)
          3'b000:  res = {63'b0, a == b};
          3'b001:  res = {63'b0, a != b};
          3'b100:  res = {63'b0, $signed(a) < $signed(b)};
          3'b101:  res = {63'b0, $signed(a) >= $signed(b)};
          3'b110:  res = {63'b0, a < b};
          3'b111:  res = {63'b0, a >= b};
          default: res = '0;
        endcase
      end
      default: res = '0; // system
    endcase
    if (word)
      res = {{32{res[31]}}, res[31:0]};
    return res;
  endfunction

  function automatic logic [63:0] div_ref(input exu_req_t r);
    logic        word;
    logic        sgn;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] ma;
    logic [63:0] mb;
    logic [63:0] q;
    logic [63:0] rm;
    logic [63:0] res;
    word = r.opcode == `EXU_OP_R64;
    sgn = !r.func3[0];
    if (word) begin
      a = sgn ? {{32{r.src1[31]}}, r.src1[31:0]} : {32'b0, r.src1[31:0]};
      b = sgn ? {{32{r.src2[31]}}, r.src2[31:0]} : {32'b0, r.src2[31:0]};
    end else begin
      a = r.src1;
      b = r.src2;
    end
    if (b == '0) begin
      q = '1;
      rm = a;
    end else if (sgn && a == {1'b1, 63'b0} && b == '1) begin
      q = a;
      rm = '0;
    end else begin
      ma = (sgn && a[63]) ? -a : a;
      mb = (sgn && b[63]) ? -b : b;
      q = ma / mb;
      rm = ma % mb;
      if (sgn && (a[63] ^ b[63]))
        q = -q;
      if (sgn && a[63])
        rm = -rm; // truncating division
    end
    res = r.func3[1] ? rm : q;
    if (word)
      res = {{32{res[31]}}, res[31:0]};
    return res;
  endfunction

  function automatic logic [63:0] ref_result(input exu_req_t r);
    logic [127:0] ea;
    logic [127:0] eb;
    logic [127:0] prod;
    if (r.mul_en) begin
      ea = (r.func3 == 3'b011) ? {64'b0, r.src1} : {{64{r.src1[63]}}, r.src1};
      eb = r.func3[1] ? {64'b0, r.src2} : {{64{r.src2[63]}}, r.src2};
      prod = ea * eb;
      if (r.opcode == `EXU_OP_R64)
        return {{32{prod[31]}}, prod[31:0]};
      return (r.func3 == 3'b000) ? prod[63:0] : prod[127:64];
    end
    if (r.div_en)
      return div_ref(r);
    return alu_ref(r);
  endfunction

  result_check: assert property (@(posedge clk) disable iff (reset_i)
      (valid_i && ready_i) |-> (result_i == ref_result(req_i)))
    else begin
      $error("Error at %0t: result_o expected %h got %h", $time,
             ref_result($sampled(req_i)), $sampled(result_i));
      fail_cnt++;
    end

  mul_latency: assert property (@(posedge clk) disable iff (reset_i)
      mul_load_i |=> !ready_i [*64] ##1 ready_i)
    else begin
      $error("Error at %0t: mul ready_o did not come exactly 65 cycles after start", $time);
      fail_cnt++;
    end

  div_latency: assert property (@(posedge clk) disable iff (reset_i)
      div_load_i |=> !ready_i [*65] ##1 ready_i)
    else begin
      $error("Error at %0t: div ready_o did not come exactly 66 cycles after start", $time);
      fail_cnt++;
    end

  done_after_reset: assert property (@(posedge clk)
      reset_i |=> (!mul_done_i && !div_done_i))
    else begin
      $error("Error at %0t: done_o expected 0 got mul %b div %b", $time,
             $sampled(mul_done_i), $sampled(div_done_i));
      fail_cnt++;
    end

endmodule

bind exu_top exu_checker exu_checker_inst (
  .clk        (clk),
  .reset_i    (reset_i),
  .req_i      (req_i),
  .valid_i    (valid_i),
  .ready_i    (ready_o),
  .result_i   (result_o),
  .mul_load_i (exu_mul_inst.load),
  .div_load_i (exu_div_inst.load),
  .mul_done_i (mul_done),
  .div_done_i (div_done)
);

/* verif/exu_tb.sv */
`include "exu_params.svh"

module exu_tb
  import exu_pkg::*;
();

  localparam int NUM_ALU = 133;
  localparam int NUM_MD = 72;
  localparam int WATCHDOG_CYCLES = (NUM_MD * 70 + NUM_ALU * 2 + 100) * 2;

  logic                 clk;
  logic                 reset;
  exu_req_t             req;
  logic                 valid;
  logic                 ready;
  logic [`EXU_XLEN-1:0] result;
  logic [31:0]          seed;
  int                   tb_errors;
  int                   errors_seen;
  int                   passed;

  exu_top exu_top_inst (
    .clk      (clk),
    .reset_i  (reset),
    .req_i    (req),
    .valid_i  (valid),
    .ready_o  (ready),
    .result_o (result)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * 8);
    $display("watchdog expired, the tests did not finish in time");
    $display("TB FAILED");
    $finish;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [63:0] edge_value(input logic [2:0] k);
    case (k)
      3'd0:    return 64'h0;
      3'd1:    return 64'h1;
      3'd2:    return '1;
      3'd3:    return 64'h8000_0000_0000_0000;
      3'd4:    return 64'h7fff_ffff_ffff_ffff;
      3'd5:    return 64'h0000_0000_8000_0000;
      3'd6:    return 64'h0000_0000_7fff_ffff;
      default: return 64'hffff_ffff_8000_0000;
    endcase
  endfunction

  task automatic get_rand64(output logic [63:0] v);
    seed = xorshift(seed);
    v[63:32] = seed;
    seed = xorshift(seed);
    v[31:0] = seed;
  endtask

  task automatic rand_operand(input int idx, output logic [63:0] v);
    logic [63:0] r;
    get_rand64(r);
    if (idx % 3 == 0)
      v = edge_value(r[2:0]); // every third operand from the corners
    else
      v = r;
  endtask

  // hold the request until ready_o, then let the next edge accept it
  task automatic run_req(input logic [6:0] opc, input logic [2:0] f3, input logic alt,
                         input logic mul, input logic div, input logic [63:0] a,
                         input logic [63:0] b);
    int waited;
    @(negedge clk);
    req.src1 = a;
    req.src2 = b;
    req.opcode = opc;
    req.func3 = f3;
    req.func7_alt = alt;
    req.mul_en = mul;
    req.div_en = div;
    valid = 1'b1;
    @(negedge clk);
    waited = 1;
    while (!ready && waited < 100) begin
      @(negedge clk);
      waited++;
    end
    if (!ready) begin
      $display("request with opcode %b func3 %b never got ready_o", opc, f3);
      tb_errors++;
    end
  endtask

  task automatic finish_test(input int num, input string name);
    int total;
    @(negedge clk);
    valid = 1'b0;
    req = '0;
    @(negedge clk);
    total = exu_top_inst.exu_checker_inst.fail_cnt + tb_errors;
    if (total == errors_seen)
      passed++;
    $display("test %0d %s: %0d failures", num, name, total - errors_seen);
    errors_seen = total;
  endtask

  initial begin
    logic [63:0] a;
    logic [63:0] b;
    logic [2:0]  f3;
    seed = 32'hc614_f94f;
    tb_errors = 0;
    errors_seen = 0;
    passed = 0;
    reset = 1'b1;
    valid = 1'b0;
    req = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    for (int i = 0; i < 48; i++) begin
      rand_operand(i, a);
      rand_operand(i + 1, b);
      case (i % 12)
        0:  run_req(`EXU_OP_R, 3'b000, 1'b0, 1'b0, 1'b0, a, b);
        1:  run_req(`EXU_OP_R, 3'b000, 1'b1, 1'b0, 1'b0, a, b); // sub
        2:  run_req(`EXU_OP_R, 3'b111, 1'b0, 1'b0, 1'b0, a, b);
        3:  run_req(`EXU_OP_R, 3'b110, 1'b0, 1'b0, 1'b0, a, b);
        4:  run_req(`EXU_OP_R, 3'b100, 1'b0, 1'b0, 1'b0, a, b);
        5:  run_req(`EXU_OP_R, 3'b010, 1'b0, 1'b0, 1'b0, a, b);
        6:  run_req(`EXU_OP_R, 3'b011, 1'b0, 1'b0, 1'b0, a, b);
        7:  run_req(`EXU_OP_I, 3'b000, 1'b1, 1'b0, 1'b0, a, b); // addi ignores alt
        8:  run_req(`EXU_OP_LUI, 3'b000, 1'b0, 1'b0, 1'b0, a, b);
        9:  run_req(`EXU_OP_AUIPC, 3'b000, 1'b0, 1'b0, 1'b0, a, b);
        10: run_req(`EXU_OP_LOAD, 3'b011, 1'b0, 1'b0, 1'b0, a, b);
        default: run_req(`EXU_OP_STORE, 3'b011, 1'b0, 1'b0, 1'b0, a, b);
      endcase
    end
    finish_test(1, "alu arithmetic and address");

    for (int i = 0; i < 42; i++) begin
      rand_operand(i, a);
      get_rand64(b);
      case (i % 7)
        0: run_req(`EXU_OP_R, 3'b001, 1'b0, 1'b0, 1'b0, a, b);
        1: run_req(`EXU_OP_R, 3'b101, 1'b0, 1'b0, 1'b0, a, b);
        2: run_req(`EXU_OP_R, 3'b101, 1'b1, 1'b0, 1'b0, a, b);
        3: run_req(`EXU_OP_R64, 3'b001, 1'b0, 1'b0, 1'b0, a, b);
        4: run_req(`EXU_OP_R64, 3'b101, 1'b0, 1'b0, 1'b0, a, b);
        5: run_req(`EXU_OP_R64, 3'b101, 1'b1, 1'b0, 1'b0, a, b);
        default: run_req(`EXU_OP_R64, 3'b000, 1'b0, 1'b0, 1'b0, a, b);
      endcase
    end
    finish_test(2, "shifts and word forms");

    for (int i = 0; i < 42; i++) begin
      rand_operand(i, a);
      rand_operand(i + 2, b);
      if (i % 4 == 0)
        b = a;
      f3 = (i % 6 < 2) ? 3'(i % 6) : 3'(i % 6 + 2); // skips 010 and 011
      if (i < 36)
        run_req(`EXU_OP_BRANCH, f3, 1'b0, 1'b0, 1'b0, a, b);
      else if (i < 40)
        run_req(`EXU_OP_JALR, 3'b000, 1'b0, 1'b0, 1'b0, a, b);
      else
        run_req(`EXU_OP_SYSTEM, 3'b000, 1'b0, 1'b0, 1'b0, a, b);
    end
    finish_test(3, "branch jalr system");

    for (int i = 0; i < 30; i++) begin
      rand_operand(i, a);
      rand_operand(i + 1, b);
      if (i % 5 == 4)
        run_req(`EXU_OP_R64, 3'b000, 1'b0, 1'b1, 1'b0, a, b); // mulw
      else
        run_req(`EXU_OP_R, 3'(i % 5), 1'b0, 1'b1, 1'b0, a, b);
    end
    finish_test(4, "multiply");

    for (int i = 0; i < 40; i++) begin
      rand_operand(i, a);
      rand_operand(i + 1, b);
      if (i / 8 == 0) begin
        b = '0;
      end else if (i / 8 == 1) begin
        a = (i % 8 >= 4) ? 64'h0000_0000_8000_0000 : 64'h8000_0000_0000_0000;
        b = '1;
      end
      f3 = {1'b1, 2'(i % 4)};
      if (i % 8 >= 4)
        run_req(`EXU_OP_R64, f3, 1'b0, 1'b0, 1'b1, a, b);
      else
        run_req(`EXU_OP_R, f3, 1'b0, 1'b0, 1'b1, a, b);
    end
    finish_test(5, "divide");

    @(negedge clk);
    reset = 1'b1;
    repeat (2) @(negedge clk);
    reset = 1'b0;
    get_rand64(a);
    get_rand64(b);
    run_req(`EXU_OP_R, 3'b011, 1'b0, 1'b1, 1'b0, a, b);
    run_req(`EXU_OP_R, 3'b100, 1'b0, 1'b0, 1'b1, a, b);
    run_req(`EXU_OP_R, 3'b000, 1'b0, 1'b0, 1'b0, a, b);
    finish_test(6, "back to back");

    $display("tests run 6, passed %0d, failed %0d, check failures %0d",
             passed, 6 - passed, errors_seen);
    if (errors_seen == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

/* exu.f */
+incdir+source
source/exu_pkg.sv
source/exu_op_decode.sv
source/exu_alu.sv
source/exu_mul.sv
source/exu_div.sv
source/exu_top.sv
verif/exu_checker.sv
verif/exu_tb.sv
